// File: Bender.yml
package:
  name: axi_xbar

sources:
  - include_dirs:
      - design
    files:
      - design/axi_xbar_pkg.sv
      - design/axi_read_router.sv
      - design/axi_write_router.sv
      - design/axi_xbar.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_axi_xbar.sv

// File: design/axi_read_router.sv
//##########################################################
// axi read router
// picks data port over fetch, forwards AR to main bus or
// timer, steers the R burst back to the owner
//##########################################################
`include "axi_xbar_defs.svh"

module axi_read_router
	import xbar_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic arvalid_if,
	output logic arready_if,
	input  logic [`XBAR_ID_W-1:0] arid_if,
	input  logic [`XBAR_ADDR_W-1:0] araddr_if,
	input  logic [`XBAR_LEN_W-1:0] arlen_if,
	output logic rvalid_if,
	input  logic rready_if,
	output logic [`XBAR_ID_W-1:0] rid_if,
	output logic [`XBAR_DATA_W-1:0] rdata_if,
	output logic [1:0] rresp_if,
	output logic rlast_if,
	input  logic arvalid_dm,
	output logic arready_dm,
	input  logic [`XBAR_ID_W-1:0] arid_dm,
	input  logic [`XBAR_ADDR_W-1:0] araddr_dm,
	input  logic [`XBAR_LEN_W-1:0] arlen_dm,
	output logic rvalid_dm,
	input  logic rready_dm,
	output logic [`XBAR_ID_W-1:0] rid_dm,
	output logic [`XBAR_DATA_W-1:0] rdata_dm,
	output logic [1:0] rresp_dm,
	output logic rlast_dm,
	output logic arvalid_bus,
	input  logic arready_bus,
	output logic [`XBAR_ID_W-1:0] arid_bus,
	output logic [`XBAR_ADDR_W-1:0] araddr_bus,
	output logic [`XBAR_LEN_W-1:0] arlen_bus,
	input  logic rvalid_bus,
	output logic rready_bus,
	input  logic [`XBAR_ID_W-1:0] rid_bus,
	input  logic [`XBAR_DATA_W-1:0] rdata_bus,
	input  logic [1:0] rresp_bus,
	input  logic rlast_bus,
	output logic arvalid_tmr,
	input  logic arready_tmr,
	output logic [`XBAR_ID_W-1:0] arid_tmr,
	output logic [`XBAR_ADDR_W-1:0] araddr_tmr,
	output logic [`XBAR_LEN_W-1:0] arlen_tmr,
	input  logic rvalid_tmr,
	output logic rready_tmr,
	input  logic [`XBAR_ID_W-1:0] rid_tmr,
	input  logic [`XBAR_DATA_W-1:0] rdata_tmr,
	input  logic [1:0] rresp_tmr,
	input  logic rlast_tmr
);

	xbar_chan_e rd_state;
	rd_owner_e rd_owner;
	xbar_target_e rd_target;

	rd_owner_e req_owner;
	xbar_target_e req_target;
	logic req_valid;
	logic req_ready;
	logic [`XBAR_ID_W-1:0] req_id;
	logic [`XBAR_ADDR_W-1:0] req_addr;
	logic [`XBAR_LEN_W-1:0] req_len;

	logic rd_idle;
	logic ar_fire;
	logic ar_to_bus;
	logic ar_to_tmr;
	logic r_to_dm;
	logic r_to_if;
	logic r_done;

	logic sel_rvalid;
	logic sel_rready;
	logic sel_rlast;
	logic [`XBAR_ID_W-1:0] sel_rid;
	logic [`XBAR_DATA_W-1:0] sel_rdata;
	logic [1:0] sel_rresp;

	assign rd_idle = (rd_state == CHAN_IDLE);

	// data port first; fetch always lands on main bus
	always_comb begin
		if (arvalid_dm) begin
			req_owner = OWNER_DATA;
			req_valid = 1'b1;
			req_id = arid_dm;
			req_len = arlen_dm;
			req_target = decode_target(araddr_dm);
			req_addr = (req_target == TIMER) ? araddr_dm - `TIMER_BASE : araddr_dm;
		end else begin
			req_owner = OWNER_FETCH;
			req_valid = arvalid_if;
			req_id = arid_if;
			req_len = arlen_if;
			req_target = MAIN_BUS;
			req_addr = araddr_if;
		end
	end

	assign req_ready = (req_target == TIMER) ? arready_tmr : arready_bus;
	assign ar_fire = rd_idle && req_valid && req_ready;
	assign ar_to_bus = rd_idle && req_valid && (req_target == MAIN_BUS);
	assign ar_to_tmr = rd_idle && req_valid && (req_target == TIMER);

	assign arvalid_bus = ar_to_bus;
	assign arid_bus = ar_to_bus ? req_id : '0;
	assign araddr_bus = ar_to_bus ? req_addr : '0;
	assign arlen_bus = ar_to_bus ? req_len : '0;
	assign arvalid_tmr = ar_to_tmr;
	assign arid_tmr = ar_to_tmr ? req_id : '0;
	assign araddr_tmr = ar_to_tmr ? req_addr : '0;
	assign arlen_tmr = ar_to_tmr ? req_len : '0;

	assign arready_dm = rd_idle && (req_owner == OWNER_DATA) && req_ready;
	assign arready_if = rd_idle && (req_owner == OWNER_FETCH) && req_ready;

	// R beats from the registered target
	assign sel_rvalid = (rd_target == TIMER) ? rvalid_tmr : rvalid_bus;
	assign sel_rid = (rd_target == TIMER) ? rid_tmr : rid_bus;
	assign sel_rdata = (rd_target == TIMER) ? rdata_tmr : rdata_bus;
	assign sel_rresp = (rd_target == TIMER) ? rresp_tmr : rresp_bus;
	assign sel_rlast = (rd_target == TIMER) ? rlast_tmr : rlast_bus;
	assign sel_rready = (rd_owner == OWNER_DATA) ? rready_dm : rready_if;

	assign r_to_dm = !rd_idle && (rd_owner == OWNER_DATA);
	assign r_to_if = !rd_idle && (rd_owner == OWNER_FETCH);

	assign rvalid_dm = r_to_dm && sel_rvalid;
	assign rid_dm = r_to_dm ? sel_rid : '0;
	assign rdata_dm = r_to_dm ? sel_rdata : '0;
	assign rresp_dm = r_to_dm ? sel_rresp : '0;
	assign rlast_dm = r_to_dm && sel_rlast;
	assign rvalid_if = r_to_if && sel_rvalid;
	assign rid_if = r_to_if ? sel_rid : '0;
	assign rdata_if = r_to_if ? sel_rdata : '0;
	assign rresp_if = r_to_if ? sel_rresp : '0;
	assign rlast_if = r_to_if && sel_rlast;

	assign rready_bus = !rd_idle && (rd_target == MAIN_BUS) && sel_rready;
	assign rready_tmr = !rd_idle && (rd_target == TIMER) && sel_rready;

	// burst closes on the rlast handshake
	assign r_done = !rd_idle && sel_rvalid && sel_rready && sel_rlast;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= CHAN_IDLE;
			rd_owner <= OWNER_DATA;
			rd_target <= MAIN_BUS;
		end else if (ar_fire) begin
			rd_state <= CHAN_BUSY;
			rd_owner <= req_owner;
			rd_target <= req_target;
		end else if (r_done) begin
			rd_state <= CHAN_IDLE;
		end
	end

endmodule

// File: design/axi_write_router.sv
//##########################################################
// axi write router
// decodes the data port AW, then routes W beats and the
// B response to and from the chosen subordinate
//##########################################################
`include "axi_xbar_defs.svh"

module axi_write_router
	import xbar_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic awvalid_dm,
	output logic awready_dm,
	input  logic [`XBAR_ID_W-1:0] awid_dm,
	input  logic [`XBAR_ADDR_W-1:0] awaddr_dm,
	input  logic [`XBAR_LEN_W-1:0] awlen_dm,
	input  logic wvalid_dm,
	output logic wready_dm,
	input  logic [`XBAR_DATA_W-1:0] wdata_dm,
	input  logic [`XBAR_STRB_W-1:0] wstrb_dm,
	input  logic wlast_dm,
	output logic bvalid_dm,
	input  logic bready_dm,
	output logic [`XBAR_ID_W-1:0] bid_dm,
	output logic [1:0] bresp_dm,
	output logic awvalid_bus,
	input  logic awready_bus,
	output logic [`XBAR_ID_W-1:0] awid_bus,
	output logic [`XBAR_ADDR_W-1:0] awaddr_bus,
	output logic [`XBAR_LEN_W-1:0] awlen_bus,
	output logic wvalid_bus,
	input  logic wready_bus,
	output logic [`XBAR_DATA_W-1:0] wdata_bus,
	output logic [`XBAR_STRB_W-1:0] wstrb_bus,
	output logic wlast_bus,
	input  logic bvalid_bus,
	output logic bready_bus,
	input  logic [`XBAR_ID_W-1:0] bid_bus,
	input  logic [1:0] bresp_bus,
	output logic awvalid_tmr,
	input  logic awready_tmr,
	output logic [`XBAR_ID_W-1:0] awid_tmr,
	output logic [`XBAR_ADDR_W-1:0] awaddr_tmr,
	output logic [`XBAR_LEN_W-1:0] awlen_tmr,
	output logic wvalid_tmr,
	input  logic wready_tmr,
	output logic [`XBAR_DATA_W-1:0] wdata_tmr,
	output logic [`XBAR_STRB_W-1:0] wstrb_tmr,
	output logic wlast_tmr,
	input  logic bvalid_tmr,
	output logic bready_tmr,
	input  logic [`XBAR_ID_W-1:0] bid_tmr,
	input  logic [1:0] bresp_tmr
);

	xbar_chan_e wr_state;
	xbar_target_e wr_target;

	xbar_target_e aw_target;
	logic [`XBAR_ADDR_W-1:0] aw_addr;
	logic aw_ready;
	logic aw_fire;
	logic aw_to_bus;
	logic aw_to_tmr;
	logic wr_idle;
	logic w_to_bus;
	logic w_to_tmr;
	logic sel_bvalid;
	logic b_done;

	assign wr_idle = (wr_state == CHAN_IDLE);

	assign aw_target = decode_target(awaddr_dm);
	assign aw_addr = (aw_target == TIMER) ? awaddr_dm - `TIMER_BASE : awaddr_dm;
	assign aw_ready = (aw_target == TIMER) ? awready_tmr : awready_bus;
	assign aw_fire = wr_idle && awvalid_dm && aw_ready;
	assign aw_to_bus = wr_idle && awvalid_dm && (aw_target == MAIN_BUS);
	assign aw_to_tmr = wr_idle && awvalid_dm && (aw_target == TIMER);

	assign awready_dm = wr_idle && aw_ready;
	assign awvalid_bus = aw_to_bus;
	assign awid_bus = aw_to_bus ? awid_dm : '0;
	assign awaddr_bus = aw_to_bus ? aw_addr : '0;
	assign awlen_bus = aw_to_bus ? awlen_dm : '0;
	assign awvalid_tmr = aw_to_tmr;
	assign awid_tmr = aw_to_tmr ? awid_dm : '0;
	assign awaddr_tmr = aw_to_tmr ? aw_addr : '0;
	assign awlen_tmr = aw_to_tmr ? awlen_dm : '0;

	// W beats only flow once AW is through
	assign w_to_bus = !wr_idle && (wr_target == MAIN_BUS);
	assign w_to_tmr = !wr_idle && (wr_target == TIMER);

	assign wvalid_bus = w_to_bus && wvalid_dm;
	assign wdata_bus = w_to_bus ? wdata_dm : '0;
	assign wstrb_bus = w_to_bus ? wstrb_dm : '0;
	assign wlast_bus = w_to_bus && wlast_dm;
	assign wvalid_tmr = w_to_tmr && wvalid_dm;
	assign wdata_tmr = w_to_tmr ? wdata_dm : '0;
	assign wstrb_tmr = w_to_tmr ? wstrb_dm : '0;
	assign wlast_tmr = w_to_tmr && wlast_dm;
	assign wready_dm = (w_to_bus && wready_bus) || (w_to_tmr && wready_tmr);

	// B response back from the same target
	assign sel_bvalid = (wr_target == TIMER) ? bvalid_tmr : bvalid_bus;
	assign bvalid_dm = !wr_idle && sel_bvalid;
	assign bid_dm = wr_idle ? '0 : ((wr_target == TIMER) ? bid_tmr : bid_bus);
	assign bresp_dm = wr_idle ? '0 : ((wr_target == TIMER) ? bresp_tmr : bresp_bus);
	assign bready_bus = w_to_bus && bready_dm;
	assign bready_tmr = w_to_tmr && bready_dm;

	assign b_done = bvalid_dm && bready_dm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_state <= CHAN_IDLE;
			wr_target <= MAIN_BUS;
		end else if (aw_fire) begin
			wr_state <= CHAN_BUSY;
			wr_target <= aw_target;
		end else if (b_done) begin
			wr_state <= CHAN_IDLE;
		end
	end

endmodule

// File: design/axi_xbar.sv
//##########################################################
// axi crossbar top
// fetch and data managers onto main bus and timer, with
// independent read and write routers
//##########################################################
`include "axi_xbar_defs.svh"

module axi_xbar (
	input  logic clk,
	input  logic rst_n,
	// fetch manager, read only
	input  logic arvalid_if,
	output logic arready_if,
	input  logic [`XBAR_ID_W-1:0] arid_if,
	input  logic [`XBAR_ADDR_W-1:0] araddr_if,
	input  logic [`XBAR_LEN_W-1:0] arlen_if,
	output logic rvalid_if,
	input  logic rready_if,
	output logic [`XBAR_ID_W-1:0] rid_if,
	output logic [`XBAR_DATA_W-1:0] rdata_if,
	output logic [1:0] rresp_if,
	output logic rlast_if,
	// data manager
	input  logic arvalid_dm,
	output logic arready_dm,
	input  logic [`XBAR_ID_W-1:0] arid_dm,
	input  logic [`XBAR_ADDR_W-1:0] araddr_dm,
	input  logic [`XBAR_LEN_W-1:0] arlen_dm,
	output logic rvalid_dm,
	input  logic rready_dm,
	output logic [`XBAR_ID_W-1:0] rid_dm,
	output logic [`XBAR_DATA_W-1:0] rdata_dm,
	output logic [1:0] rresp_dm,
	output logic rlast_dm,
	input  logic awvalid_dm,
	output logic awready_dm,
	input  logic [`XBAR_ID_W-1:0] awid_dm,
	input  logic [`XBAR_ADDR_W-1:0] awaddr_dm,
	input  logic [`XBAR_LEN_W-1:0] awlen_dm,
	input  logic wvalid_dm,
	output logic wready_dm,
	input  logic [`XBAR_DATA_W-1:0] wdata_dm,
	input  logic [`XBAR_STRB_W-1:0] wstrb_dm,
	input  logic wlast_dm,
	output logic bvalid_dm,
	input  logic bready_dm,
	output logic [`XBAR_ID_W-1:0] bid_dm,
	output logic [1:0] bresp_dm,
	// main bus
	output logic arvalid_bus,
	input  logic arready_bus,
	output logic [`XBAR_ID_W-1:0] arid_bus,
	output logic [`XBAR_ADDR_W-1:0] araddr_bus,
	output logic [`XBAR_LEN_W-1:0] arlen_bus,
	input  logic rvalid_bus,
	output logic rready_bus,
	input  logic [`XBAR_ID_W-1:0] rid_bus,
	input  logic [`XBAR_DATA_W-1:0] rdata_bus,
	input  logic [1:0] rresp_bus,
	input  logic rlast_bus,
	output logic awvalid_bus,
	input  logic awready_bus,
	output logic [`XBAR_ID_W-1:0] awid_bus,
	output logic [`XBAR_ADDR_W-1:0] awaddr_bus,
	output logic [`XBAR_LEN_W-1:0] awlen_bus,
	output logic wvalid_bus,
	input  logic wready_bus,
	output logic [`XBAR_DATA_W-1:0] wdata_bus,
	output logic [`XBAR_STRB_W-1:0] wstrb_bus,
	output logic wlast_bus,
	input  logic bvalid_bus,
	output logic bready_bus,
	input  logic [`XBAR_ID_W-1:0] bid_bus,
	input  logic [1:0] bresp_bus,
	// timer, addresses relative to the window base
	output logic arvalid_tmr,
	input  logic arready_tmr,
	output logic [`XBAR_ID_W-1:0] arid_tmr,
	output logic [`XBAR_ADDR_W-1:0] araddr_tmr,
	output logic [`XBAR_LEN_W-1:0] arlen_tmr,
	input  logic rvalid_tmr,
	output logic rready_tmr,
	input  logic [`XBAR_ID_W-1:0] rid_tmr,
	input  logic [`XBAR_DATA_W-1:0] rdata_tmr,
	input  logic [1:0] rresp_tmr,
	input  logic rlast_tmr,
	output logic awvalid_tmr,
	input  logic awready_tmr,
	output logic [`XBAR_ID_W-1:0] awid_tmr,
	output logic [`XBAR_ADDR_W-1:0] awaddr_tmr,
	output logic [`XBAR_LEN_W-1:0] awlen_tmr,
	output logic wvalid_tmr,
	input  logic wready_tmr,
	output logic [`XBAR_DATA_W-1:0] wdata_tmr,
	output logic [`XBAR_STRB_W-1:0] wstrb_tmr,
	output logic wlast_tmr,
	input  logic bvalid_tmr,
	output logic bready_tmr,
	input  logic [`XBAR_ID_W-1:0] bid_tmr,
	input  logic [1:0] bresp_tmr
);

	// port names match one to one
	axi_read_router i_read_router (.*);

	axi_write_router i_write_router (.*);

endmodule

// File: design/axi_xbar_defs.svh
//##########################################################
// axi crossbar parameters
// bus widths and the timer address window
//##########################################################
`ifndef AXI_XBAR_DEFS_SVH
`define AXI_XBAR_DEFS_SVH

`define XBAR_ADDR_W 32
`define XBAR_DATA_W 64
`define XBAR_STRB_W 8
`define XBAR_ID_W 4
`define XBAR_LEN_W 8

// timer window, inclusive on both ends
`define TIMER_BASE 32'h0200_0000
`define TIMER_LAST 32'h0200_FFFF

`endif

// File: design/axi_xbar_pkg.sv
//##########################################################
// axi crossbar package
// channel state, owner and target types, address decode
//##########################################################
`include "axi_xbar_defs.svh"

package xbar_pkg;

	typedef enum logic {
		MAIN_BUS,
		TIMER
	} xbar_target_e;

	typedef enum logic {
		CHAN_IDLE,
		CHAN_BUSY
	} xbar_chan_e;

	typedef enum logic {
		OWNER_DATA,
		OWNER_FETCH
	} rd_owner_e;

	// timer window hit, everything else is main bus
	function automatic xbar_target_e decode_target(input logic [`XBAR_ADDR_W-1:0] addr);
		if ((addr >= `TIMER_BASE) && (addr <= `TIMER_LAST)) begin
			return TIMER;
		end
		return MAIN_BUS;
	endfunction

endpackage

// File: list.f
+incdir+design
design/axi_xbar_pkg.sv
design/axi_read_router.sv
design/axi_write_router.sv
design/axi_xbar.sv
tests/tb_axi_xbar.sv

// File: tests/tb_axi_xbar.sv
//##########################################################
// axi crossbar testbench
// random fetch and data traffic against two subordinate
// models, with routing and data predicted per transfer
//##########################################################
`include "axi_xbar_defs.svh"

// subordinate with bounded random ready/valid delays
module sub_model #(
	parameter logic [`XBAR_DATA_W-1:0] TAG = '0,
	parameter int MAX_DLY = 3
) (
	input  logic clk,
	input  logic arvalid,
	output logic arready,
	input  logic [`XBAR_ID_W-1:0] arid,
	input  logic [`XBAR_ADDR_W-1:0] araddr,
	input  logic [`XBAR_LEN_W-1:0] arlen,
	output logic rvalid,
	input  logic rready,
	output logic [`XBAR_ID_W-1:0] rid,
	output logic [`XBAR_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	input  logic awvalid,
	output logic awready,
	input  logic [`XBAR_ID_W-1:0] awid,
	input  logic wvalid,
	output logic wready,
	input  logic wlast,
	output logic bvalid,
	input  logic bready,
	output logic [`XBAR_ID_W-1:0] bid,
	output logic [1:0] bresp
);
	timeunit 1ns;
	timeprecision 1ps;

	logic rd_busy;
	logic wr_busy;
	logic b_pend;
	logic hs_ar, hs_r, hs_aw, hs_w, hs_b;
	logic [`XBAR_DATA_W-1:0] rd_base;
	logic [`XBAR_LEN_W-1:0] rd_len;
	logic [`XBAR_ID_W-1:0] rd_id;
	logic [`XBAR_ID_W-1:0] wr_id;
	int rd_beat;
	int ar_wait, r_wait, aw_wait, w_wait, b_wait;

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rid = '0;
		rdata = '0;
		rresp = 2'b00;
		rlast = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bid = '0;
		bresp = 2'b00;
		rd_busy = 1'b0;
		wr_busy = 1'b0;
		b_pend = 1'b0;
		rd_beat = 0;
		rd_id = '0;
		wr_id = '0;
		ar_wait = 0;
		r_wait = 0;
		aw_wait = 0;
		w_wait = 0;
		b_wait = 0;
		forever begin
			@(posedge clk);
			hs_ar = arvalid && arready;
			hs_r = rvalid && rready;
			hs_aw = awvalid && awready;
			hs_w = wvalid && wready;
			hs_b = bvalid && bready;
			// delays only run down while something waits
			if (arvalid && ar_wait > 0) ar_wait--;
			if (rd_busy && !rvalid && r_wait > 0) r_wait--;
			if (awvalid && aw_wait > 0) aw_wait--;
			if (wvalid && w_wait > 0) w_wait--;
			if (b_pend && !bvalid && b_wait > 0) b_wait--;
			if (hs_ar) begin
				rd_busy = 1'b1;
				rd_base = araddr;
				rd_len = arlen;
				rd_id = arid;
				rd_beat = 0;
				ar_wait = $urandom_range(0, MAX_DLY);
				r_wait = $urandom_range(0, MAX_DLY);
			end
			if (hs_r) begin
				if (rlast) begin
					rd_busy = 1'b0;
				end else begin
					rd_beat++;
				end
				r_wait = $urandom_range(0, MAX_DLY);
			end
			if (hs_aw) begin
				wr_busy = 1'b1;
				wr_id = awid;
				aw_wait = $urandom_range(0, MAX_DLY);
			end
			if (hs_w) begin
				w_wait = $urandom_range(0, MAX_DLY);
				if (wlast) begin
					b_pend = 1'b1;
					b_wait = $urandom_range(0, MAX_DLY);
				end
			end
			if (hs_b) begin
				wr_busy = 1'b0;
				b_pend = 1'b0;
			end
			@(negedge clk);
			arready = !rd_busy && (ar_wait == 0);
			awready = !wr_busy && (aw_wait == 0);
			wready = wr_busy && !b_pend && (w_wait == 0);
			// an offered beat stays put until taken
			if (!rvalid || hs_r) begin
				rvalid = rd_busy && (r_wait == 0);
				rid = rd_id;
				rdata = (rd_base + rd_beat) ^ TAG;
				// response code cycles with the beat number
				rresp = rd_beat[1:0];
				rlast = (rd_beat == rd_len);
			end
			if (!bvalid || hs_b) begin
				bvalid = b_pend && (b_wait == 0);
				bid = wr_id;
			end
		end
	end

endmodule

module tb_axi_xbar;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 4;
	localparam int MAX_DLY = 3;
	localparam int N_RAND = 30;
	localparam int N_MIX = 10;
	localparam int N_TXN = 3 * N_RAND + 8 + 12 + 3 * N_MIX;
	// ten handshakes per burst at most, each waiting on both sides
	localparam int WORST_CYCLES = N_TXN * 10 * (2 * MAX_DLY + 3) + 20;
	localparam logic [`XBAR_DATA_W-1:0] TAG_BUS = 64'h0b05_0000_0000_0000;
	localparam logic [`XBAR_DATA_W-1:0] TAG_TMR = 64'h07e3_0000_0000_0000;

	logic clk;
	logic rst_n;
	logic arvalid_if, arready_if, rvalid_if, rready_if, rlast_if;
	logic [`XBAR_ID_W-1:0] arid_if, rid_if;
	logic [`XBAR_ADDR_W-1:0] araddr_if;
	logic [`XBAR_LEN_W-1:0] arlen_if;
	logic [`XBAR_DATA_W-1:0] rdata_if;
	logic [1:0] rresp_if;
	logic arvalid_dm, arready_dm, rvalid_dm, rready_dm, rlast_dm;
	logic awvalid_dm, awready_dm, wvalid_dm, wready_dm, wlast_dm, bvalid_dm, bready_dm;
	logic [`XBAR_ID_W-1:0] arid_dm, rid_dm, awid_dm, bid_dm;
	logic [`XBAR_ADDR_W-1:0] araddr_dm, awaddr_dm;
	logic [`XBAR_LEN_W-1:0] arlen_dm, awlen_dm;
	logic [`XBAR_DATA_W-1:0] rdata_dm, wdata_dm;
	logic [`XBAR_STRB_W-1:0] wstrb_dm;
	logic [1:0] rresp_dm, bresp_dm;
	logic arvalid_bus, arready_bus, rvalid_bus, rready_bus, rlast_bus;
	logic awvalid_bus, awready_bus, wvalid_bus, wready_bus, wlast_bus, bvalid_bus, bready_bus;
	logic [`XBAR_ID_W-1:0] arid_bus, rid_bus, awid_bus, bid_bus;
	logic [`XBAR_ADDR_W-1:0] araddr_bus, awaddr_bus;
	logic [`XBAR_LEN_W-1:0] arlen_bus, awlen_bus;
	logic [`XBAR_DATA_W-1:0] rdata_bus, wdata_bus;
	logic [`XBAR_STRB_W-1:0] wstrb_bus;
	logic [1:0] rresp_bus, bresp_bus;
	logic arvalid_tmr, arready_tmr, rvalid_tmr, rready_tmr, rlast_tmr;
	logic awvalid_tmr, awready_tmr, wvalid_tmr, wready_tmr, wlast_tmr, bvalid_tmr, bready_tmr;
	logic [`XBAR_ID_W-1:0] arid_tmr, rid_tmr, awid_tmr, bid_tmr;
	logic [`XBAR_ADDR_W-1:0] araddr_tmr, awaddr_tmr;
	logic [`XBAR_LEN_W-1:0] arlen_tmr, awlen_tmr;
	logic [`XBAR_DATA_W-1:0] rdata_tmr, wdata_tmr;
	logic [`XBAR_STRB_W-1:0] wstrb_tmr;
	logic [1:0] rresp_tmr, bresp_tmr;

	// scoreboard view of the open bursts
	logic rd_open = 1'b0;
	logic rd_fetch = 1'b0;
	logic wr_open = 1'b0;
	time t_ar_if = 0;
	time t_rlast_dm = 0;
	string test_name = "reset";

	axi_xbar i_dut (.*);

	sub_model #(.TAG(TAG_BUS), .MAX_DLY(MAX_DLY)) i_bus_model (
		.clk(clk), .arvalid(arvalid_bus), .arready(arready_bus), .arid(arid_bus),
		.araddr(araddr_bus), .arlen(arlen_bus), .rvalid(rvalid_bus), .rready(rready_bus),
		.rid(rid_bus), .rdata(rdata_bus), .rresp(rresp_bus), .rlast(rlast_bus),
		.awvalid(awvalid_bus), .awready(awready_bus), .awid(awid_bus),
		.wvalid(wvalid_bus), .wready(wready_bus), .wlast(wlast_bus),
		.bvalid(bvalid_bus), .bready(bready_bus), .bid(bid_bus), .bresp(bresp_bus)
	);

	sub_model #(.TAG(TAG_TMR), .MAX_DLY(MAX_DLY)) i_tmr_model (
		.clk(clk), .arvalid(arvalid_tmr), .arready(arready_tmr), .arid(arid_tmr),
		.araddr(araddr_tmr), .arlen(arlen_tmr), .rvalid(rvalid_tmr), .rready(rready_tmr),
		.rid(rid_tmr), .rdata(rdata_tmr), .rresp(rresp_tmr), .rlast(rlast_tmr),
		.awvalid(awvalid_tmr), .awready(awready_tmr), .awid(awid_tmr),
		.wvalid(wvalid_tmr), .wready(wready_tmr), .wlast(wlast_tmr),
		.bvalid(bvalid_tmr), .bready(bready_tmr), .bid(bid_tmr), .bresp(bresp_tmr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [`XBAR_DATA_W-1:0] expected,
			input logic [`XBAR_DATA_W-1:0] actual);
		if (expected !== actual) begin
			$display("** Error [%s] %s: expected %0h, actual %0h", test_name, name,
				expected, actual);
			$display("Result: FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// window interior, both edges of it, or anywhere
	function automatic logic [`XBAR_ADDR_W-1:0] rand_addr();
		logic [`XBAR_ADDR_W-1:0] a;
		case ($urandom_range(0, 3))
			0: a = `TIMER_BASE + $urandom % (`TIMER_LAST - `TIMER_BASE + 1);
			1: a = `TIMER_BASE - 8 * $urandom_range(1, 4);
			2: a = `TIMER_LAST + 1 + 8 * $urandom_range(0, 3);
			default: a = $urandom;
		endcase
		return {a[`XBAR_ADDR_W-1:3], 3'b000};
	endfunction

	task automatic read_burst(input bit fetch, input logic [`XBAR_ADDR_W-1:0] addr,
			input logic [`XBAR_LEN_W-1:0] len, input logic [`XBAR_ID_W-1:0] id,
			input int lead);
		bit to_tmr;
		logic [`XBAR_ADDR_W-1:0] exp_addr;
		logic [`XBAR_DATA_W-1:0] exp_data;
		int beat;
		// fetch never leaves the main bus
		to_tmr = !fetch && (addr >= `TIMER_BASE) && (addr <= `TIMER_LAST);
		exp_addr = to_tmr ? addr - `TIMER_BASE : addr;
		@(negedge clk);
		repeat (lead) @(negedge clk);
		if (fetch) begin
			arvalid_if = 1'b1;
			araddr_if = addr;
			arlen_if = len;
			arid_if = id;
		end else begin
			arvalid_dm = 1'b1;
			araddr_dm = addr;
			arlen_dm = len;
			arid_dm = id;
		end
		@(posedge clk);
		while (!(fetch ? arready_if : arready_dm)) @(posedge clk);
		check_value("ar valid at bus", !to_tmr, arvalid_bus);
		check_value("ar valid at timer", to_tmr, arvalid_tmr);
		check_value("ar addr", exp_addr, to_tmr ? araddr_tmr : araddr_bus);
		check_value("ar len", len, to_tmr ? arlen_tmr : arlen_bus);
		check_value("ar id", id, to_tmr ? arid_tmr : arid_bus);
		@(negedge clk);
		if (fetch) arvalid_if = 1'b0;
		else arvalid_dm = 1'b0;
		for (beat = 0; beat <= len; beat++) begin
			repeat ($urandom_range(0, MAX_DLY)) @(negedge clk);
			if (fetch) rready_if = 1'b1;
			else rready_dm = 1'b1;
			@(posedge clk);
			while (!(fetch ? rvalid_if : rvalid_dm)) @(posedge clk);
			exp_data = exp_addr;
			exp_data = (exp_data + beat) ^ (to_tmr ? TAG_TMR : TAG_BUS);
			check_value("r data", exp_data, fetch ? rdata_if : rdata_dm);
			check_value("r last", beat == len, fetch ? rlast_if : rlast_dm);
			check_value("r id", id, fetch ? rid_if : rid_dm);
			check_value("r resp", beat % 4, fetch ? rresp_if : rresp_dm);
			@(negedge clk);
			if (fetch) rready_if = 1'b0;
			else rready_dm = 1'b0;
		end
	endtask

	task automatic write_burst(input logic [`XBAR_ADDR_W-1:0] addr,
			input logic [`XBAR_LEN_W-1:0] len, input logic [`XBAR_ID_W-1:0] id,
			input int lead);
		bit to_tmr;
		logic [`XBAR_ADDR_W-1:0] exp_addr;
		logic [`XBAR_DATA_W-1:0] data;
		logic [`XBAR_STRB_W-1:0] strb;
		int beat;
		to_tmr = (addr >= `TIMER_BASE) && (addr <= `TIMER_LAST);
		exp_addr = to_tmr ? addr - `TIMER_BASE : addr;
		@(negedge clk);
		repeat (lead) @(negedge clk);
		fork
			begin
				awvalid_dm = 1'b1;
				awaddr_dm = addr;
				awlen_dm = len;
				awid_dm = id;
				@(posedge clk);
				while (!awready_dm) @(posedge clk);
				check_value("aw valid at bus", !to_tmr, awvalid_bus);
				check_value("aw valid at timer", to_tmr, awvalid_tmr);
				check_value("aw addr", exp_addr, to_tmr ? awaddr_tmr : awaddr_bus);
				check_value("aw len", len, to_tmr ? awlen_tmr : awlen_bus);
				check_value("aw id", id, to_tmr ? awid_tmr : awid_bus);
				@(negedge clk);
				awvalid_dm = 1'b0;
			end
			begin
				// W is offered early and has to wait for AW
				for (beat = 0; beat <= len; beat++) begin
					repeat ($urandom_range(0, MAX_DLY)) @(negedge clk);
					data = {$urandom, $urandom};
					strb = $urandom;
					wvalid_dm = 1'b1;
					wdata_dm = data;
					wstrb_dm = strb;
					wlast_dm = (beat == len);
					@(posedge clk);
					while (!wready_dm) @(posedge clk);
					check_value("w valid at target", 1, to_tmr ? wvalid_tmr : wvalid_bus);
					check_value("w valid elsewhere", 0, to_tmr ? wvalid_bus : wvalid_tmr);
					check_value("w data", data, to_tmr ? wdata_tmr : wdata_bus);
					check_value("w strb", strb, to_tmr ? wstrb_tmr : wstrb_bus);
					check_value("w last", beat == len, to_tmr ? wlast_tmr : wlast_bus);
					@(negedge clk);
					wvalid_dm = 1'b0;
				end
			end
		join
		repeat ($urandom_range(0, MAX_DLY)) @(negedge clk);
		bready_dm = 1'b1;
		@(posedge clk);
		while (!bvalid_dm) @(posedge clk);
		check_value("b id", id, bid_dm);
		check_value("b resp", 0, bresp_dm);
		@(negedge clk);
		bready_dm = 1'b0;
	endtask

	// one burst per direction, no cross traffic between managers
	always @(posedge clk) begin
		if (rst_n) begin
			check_value("fetch accepted over data", 0, arvalid_dm && arready_if);
			if (rd_open) begin
				check_value("ar while read open", 0,
					{arvalid_bus, arvalid_tmr, arready_dm, arready_if});
				check_value("r beat at other manager", 0, rd_fetch ? rvalid_dm : rvalid_if);
				if (rd_fetch && rvalid_if && rready_if && rlast_if) begin
					rd_open = 1'b0;
				end
				if (!rd_fetch && rvalid_dm && rready_dm && rlast_dm) begin
					rd_open = 1'b0;
					t_rlast_dm = $time;
				end
			end else begin
				check_value("r beat with no open read", 0, {rvalid_dm, rvalid_if});
				if (arvalid_dm && arready_dm) begin
					rd_open = 1'b1;
					rd_fetch = 1'b0;
				end else if (arvalid_if && arready_if) begin
					rd_open = 1'b1;
					rd_fetch = 1'b1;
					t_ar_if = $time;
				end
			end
			if (wr_open) begin
				check_value("aw while write open", 0, {awvalid_bus, awvalid_tmr, awready_dm});
				if (bvalid_dm && bready_dm) wr_open = 1'b0;
			end else begin
				check_value("w or b with no open write", 0,
					{wready_dm, wvalid_bus, wvalid_tmr, bvalid_dm});
				if (awvalid_dm && awready_dm) wr_open = 1'b1;
			end
		end
	end

	initial begin
		#(WORST_CYCLES * CLK_PERIOD);
		$display("watchdog: traffic did not finish within %0d cycles", WORST_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(32'hed80_0d6b));
		rst_n = 1'b0;
		arvalid_if = 1'b0;
		arid_if = '0;
		araddr_if = '0;
		arlen_if = '0;
		rready_if = 1'b0;
		arvalid_dm = 1'b0;
		arid_dm = '0;
		araddr_dm = '0;
		arlen_dm = '0;
		rready_dm = 1'b0;
		awvalid_dm = 1'b0;
		awid_dm = '0;
		awaddr_dm = '0;
		awlen_dm = '0;
		wvalid_dm = 1'b0;
		wdata_dm = '0;
		wstrb_dm = '0;
		wlast_dm = 1'b0;
		bready_dm = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("outputs idle after reset", 0, {arvalid_bus, arvalid_tmr, awvalid_bus,
			awvalid_tmr, rvalid_if, rvalid_dm, bvalid_dm, wready_dm});

		test_name = "data reads";
		repeat (N_RAND) begin
			read_burst(1'b0, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
				$urandom_range(0, MAX_DLY));
		end

		test_name = "data writes";
		repeat (N_RAND) begin
			write_burst(rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
				$urandom_range(0, MAX_DLY));
		end

		test_name = "fetch reads";
		repeat (N_RAND) begin
			read_burst(1'b1, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
				$urandom_range(0, MAX_DLY));
		end

		// both managers raise arvalid on the same edge
		test_name = "read priority";
		repeat (4) begin
			fork
				read_burst(1'b0, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15), 0);
				read_burst(1'b1, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15), 0);
			join
			check_value("fetch after data burst", 1, t_ar_if > t_rlast_dm);
		end

		test_name = "one burst per direction";
		repeat (3) begin
			fork
				read_burst(1'b0, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15), 0);
				read_burst(1'b1, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
					$urandom_range(1, MAX_DLY));
				write_burst(rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15), 0);
				begin
					// next AW goes up while the first write waits for its B
					@(posedge clk);
					while (!(wvalid_dm && wready_dm && wlast_dm)) @(posedge clk);
					@(negedge clk);
					write_burst(rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15), 0);
				end
			join
		end

		test_name = "mixed backpressure";
		fork
			repeat (N_MIX) begin
				read_burst(1'b0, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
					$urandom_range(0, MAX_DLY));
			end
			repeat (N_MIX) begin
				read_burst(1'b1, rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
					$urandom_range(0, MAX_DLY));
			end
			repeat (N_MIX) begin
				write_burst(rand_addr(), $urandom_range(0, 7), $urandom_range(0, 15),
					$urandom_range(0, MAX_DLY));
			end
		join

		repeat (4) @(negedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule
